// File: bench/softmc_checker.sv
module softmc_checker import softmc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  app_en,
	input  instr_t                app_instr,
	input  logic                  app_ack,
	input  logic                  iq_full,
	input  logic                  processing_iseq,
	input  logic                  rdback_fifo_rden,
	input  logic                  rdback_fifo_empty,
	input  rdback_t               rdback_data,
	input  logic [ROW_WIDTH-1:0]  dfi_address0,
	input  logic [ROW_WIDTH-1:0]  dfi_address1,
	input  logic [BANK_WIDTH-1:0] dfi_bank0,
	input  logic [BANK_WIDTH-1:0] dfi_bank1,
	input  logic [CKE_WIDTH-1:0]  dfi_cke0,
	input  logic [CKE_WIDTH-1:0]  dfi_cke1,
	input  logic [CS_WIDTH-1:0]   dfi_cs_n0,
	input  logic [CS_WIDTH-1:0]   dfi_cs_n1,
	input  logic                  dfi_ras_n0,
	input  logic                  dfi_ras_n1,
	input  logic                  dfi_cas_n0,
	input  logic                  dfi_cas_n1,
	input  logic                  dfi_we_n0,
	input  logic                  dfi_we_n1,
	input  logic                  dfi_wrdata_en,
	input  rdback_t               dfi_wrdata,
	input  logic                  dfi_rddata_en,
	input  logic                  dfi_rddata_valid,
	input  logic                  expect_valid,
	input  logic [7:0]            expect_byte,
	input  logic                  end_check,
	output int                    errors,
	output int                    checks
);

	instr_t     stream [$]; // accepted instructions, not yet walked
	instr_t     iq_model [$]; // instruction queue contents
	int         wr_due [$];
	logic [7:0] wr_pat [$];
	int         rd_due [$];
	logic [7:0] rb_exp [$];
	logic [7:0] pattern = '0;
	int         cycle = 0;
	int         last_ddr = -1;
	int         rb_count = 0;
	int         ends_sent = 0;
	int         pend_ends = 0;
	int         next_pop = 0;
	int         falls = 0;
	bit         exp_proc = 0;
	bit         exp_cke = 0;
	bit         cke_known = 0;
	bit         prev_proc = 0;
	bit         rst_seen = 0;
	bit         saw_full = 0;
	bit         saw_hold = 0;
	int         err_cnt = 0;
	int         chk_cnt = 0;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	task automatic report_mismatch(string name, logic [255:0] exp, logic [255:0] act);
		err_cnt++;
		$display("mismatch time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
	endtask

	task automatic report_failure(string msg);
		err_cnt++;
		$display("error at time %0t: %s", $time, msg);
	endtask

	// walk the accepted stream up to the next DDR command
	task automatic next_ddr(output instr_t d, output int gap, output bit crossed, output bit found);
		instr_t w;
		gap = 0;
		crossed = 0;
		found = 0;
		while (stream.size() > 0 && !found) begin
			w = stream.pop_front();
			case (w[31:28])
				4'b0100: begin
					d = w;
					found = 1;
				end
				4'b0001: gap += w[15:0];
				4'b1000: begin
					pattern = w[7:0];
					gap += 1;
				end
				default: begin
					crossed = 1; // END
					gap += 1;
				end
			endcase
		end
	endtask

	always @(posedge clk) begin
		instr_t d;
		instr_t w;
		int gap;
		int wait_n;
		bit crossed;
		bit found;
		bit nop0;
		bit nop1;
		bit exp_wr;
		bit exp_rd;
		bit exp_full;
		bit slot;
		logic [22:0] seen;
		nop0 = dfi_cs_n0 && dfi_ras_n0 && dfi_cas_n0 && dfi_we_n0
			&& dfi_address0 == '0 && dfi_bank0 == '0;
		nop1 = dfi_cs_n1 && dfi_ras_n1 && dfi_cas_n1 && dfi_we_n1
			&& dfi_address1 == '0 && dfi_bank1 == '0;
		if (rst) begin
			if (rst_seen) begin
				chk_cnt++;
				if (app_ack || processing_iseq || dfi_wrdata_en || dfi_rddata_en || !nop0
						|| !nop1 || iq_full || !rdback_fifo_empty)
					report_failure("outputs not inactive during reset");
			end
			rst_seen = 1;
		end else begin
			cycle++;
			// command handshake against the queue model
			exp_full = iq_model.size() == IQ_DEPTH;
			chk_cnt += 3;
			if (iq_full !== exp_full)
				report_mismatch("iq_full", exp_full, iq_full);
			if (app_ack !== (app_en && !exp_full))
				report_mismatch("app_ack", app_en && !exp_full, app_ack);
			if (processing_iseq !== exp_proc)
				report_mismatch("processing_iseq", exp_proc, processing_iseq);
			if (exp_full)
				saw_full = 1;
			if (app_en && exp_full)
				saw_hold = 1;

			// one pop per cycle once a whole sequence is queued
			if (pend_ends > 0 && cycle >= next_pop && iq_model.size() > 0) begin
				w = iq_model.pop_front();
				exp_proc = 1;
				if (w[31:28] == 4'b0001) begin
					wait_n = w[15:0];
					next_pop = cycle + ((wait_n > 1) ? wait_n : 1);
				end else if (w[31:28] == 4'b1110) begin
					pend_ends--;
					exp_proc = 0;
				end
			end
			if (app_en && !exp_full) begin
				iq_model.push_back(app_instr);
				stream.push_back(app_instr);
				if (app_instr[31:28] == 4'b1110) begin
					ends_sent++;
					pend_ends++;
				end
			end
			if (prev_proc && !processing_iseq)
				falls++;
			prev_proc = processing_iseq;

			// enables due this cycle
			exp_wr = wr_due.size() > 0 && wr_due[0] == cycle;
			exp_rd = rd_due.size() > 0 && rd_due[0] == cycle;
			chk_cnt += 2;
			if (dfi_wrdata_en !== exp_wr)
				report_mismatch("dfi_wrdata_en", exp_wr, dfi_wrdata_en);
			if (dfi_rddata_en !== exp_rd)
				report_mismatch("dfi_rddata_en", exp_rd, dfi_rddata_en);
			if (exp_wr) begin
				void'(wr_due.pop_front());
				if (dfi_wrdata !== {32{wr_pat[0]}})
					report_mismatch("dfi_wrdata", {32{wr_pat[0]}}, dfi_wrdata);
				void'(wr_pat.pop_front());
			end
			if (exp_rd)
				void'(rd_due.pop_front());

			// command slots
			if (!nop0 && !nop1) begin
				report_failure("both DFI slots carry a command in one cycle");
			end else if (!nop0 || !nop1) begin
				slot = nop0;
				seen = slot ? {dfi_cs_n1, dfi_ras_n1, dfi_cas_n1, dfi_we_n1, dfi_bank1,
					dfi_address1} : {dfi_cs_n0, dfi_ras_n0, dfi_cas_n0, dfi_we_n0,
					dfi_bank0, dfi_address0};
				next_ddr(d, gap, crossed, found);
				chk_cnt++;
				if (!found) begin
					report_failure("DFI command appeared with no DDR instruction queued");
				end else begin
					exp_cke = d[23];
					cke_known = 1;
					if (seen !== d[22:0])
						report_mismatch("dfi_command", d[22:0], seen);
					if (slot !== !d[20])
						report_mismatch("dfi_slot", !d[20], slot);
					if (!crossed && last_ddr >= 0 && cycle - last_ddr - 1 != gap)
						report_mismatch("nop_gap", gap, cycle - last_ddr - 1);
					if (!processing_iseq)
						report_failure("DDR command while processing_iseq is low");
					if (slot && !seen[22] && seen[21]) begin
						if (!seen[19]) begin
							wr_due.push_back(cycle + WR_LAT);
							wr_pat.push_back(pattern);
						end else begin
							rd_due.push_back(cycle + RD_LAT);
						end
					end
				end
				last_ddr = cycle;
			end

			// cke holds the level of the last command
			if (cke_known) begin
				chk_cnt++;
				if (dfi_cke0 !== exp_cke)
					report_mismatch("dfi_cke0", exp_cke, dfi_cke0);
				if (dfi_cke1 !== exp_cke)
					report_mismatch("dfi_cke1", exp_cke, dfi_cke1);
			end

			// read-back FIFO
			chk_cnt++;
			if (rdback_fifo_empty !== (rb_count == 0))
				report_mismatch("rdback_fifo_empty", rb_count == 0, rdback_fifo_empty);
			if (rdback_fifo_rden && !rdback_fifo_empty) begin
				if (rb_exp.size() == 0) begin
					report_failure("read-back word drained with no expected value");
				end else begin
					if (rdback_data !== {32{rb_exp[0]}})
						report_mismatch("rdback_data", {32{rb_exp[0]}}, rdback_data);
					void'(rb_exp.pop_front());
				end
				rb_count--;
			end
			if (dfi_rddata_valid)
				rb_count++;
			if (expect_valid)
				rb_exp.push_back(expect_byte);

			if (end_check) begin
				chk_cnt++;
				if (wr_due.size() != 0 || rd_due.size() != 0)
					report_failure("data enables still expected at the end of the run");
				if (rb_exp.size() != 0 || rb_count != 0)
					report_failure("read-back words left over at the end of the run");
				if (!saw_full || !saw_hold)
					report_failure("instruction queue back-pressure was never exercised");
				if (falls != ends_sent)
					report_mismatch("sequence_count", ends_sent, falls);
			end
		end
	end

endmodule

// File: bench/softmc_stimulus.txt
# I <hex>: instruction word sent to the DUT, X <hex>: pattern byte of the next drained word
# R: wait for the running sequence to end, then drain the read-back FIFO
I 40990010
I 10000003
I 800000a5
I 40a10020
I 80000033
I 40a10028
I 10000004
I 40a90020
I 40a90028
I 10000006
I 40910000
I e0000000
X a5
X 33
R
# long WAIT holds the queue while the next sequence fills it
I 100000c8
I e0000000
I 409a0020
I 10000002
I 8000005a
I 40a20040
I 40a20048
I 10000005
I 40aa0040
I 40aa0048
I 800000c3
I 40a20050
I 10000005
I 40aa0050
I 10000006
I 40920000
I 10000002
I e0000000
X 5a
X 5a
X c3
R

// File: bench/softmc_tb.sv
module softmc_tb import softmc_pkg::*; ();

	localparam int RET_DELAY = 3; // phy model read return delay

	logic                  clk = 0;
	logic                  rst = 1;
	logic                  app_en = 0;
	instr_t                app_instr = '0;
	logic                  rdback_fifo_rden = 0;
	rdback_t               dfi_rddata = '0;
	logic                  dfi_rddata_valid = 0;
	logic                  expect_valid = 0;
	logic [7:0]            expect_byte = '0;
	logic                  end_check = 0;
	logic                  app_ack;
	logic                  iq_full;
	logic                  processing_iseq;
	logic                  rdback_fifo_empty;
	rdback_t               rdback_data;
	rdback_t               dfi_wrdata;
	logic [ROW_WIDTH-1:0]  dfi_address0;
	logic [ROW_WIDTH-1:0]  dfi_address1;
	logic [BANK_WIDTH-1:0] dfi_bank0;
	logic [BANK_WIDTH-1:0] dfi_bank1;
	logic [CKE_WIDTH-1:0]  dfi_cke0;
	logic [CKE_WIDTH-1:0]  dfi_cke1;
	logic [CS_WIDTH-1:0]   dfi_cs_n0;
	logic [CS_WIDTH-1:0]   dfi_cs_n1;
	logic                  dfi_ras_n0;
	logic                  dfi_ras_n1;
	logic                  dfi_cas_n0;
	logic                  dfi_cas_n1;
	logic                  dfi_we_n0;
	logic                  dfi_we_n1;
	logic                  dfi_wrdata_en;
	logic                  dfi_rddata_en;
	int                    errors;
	int                    checks;
	int                    seed = 32'h5845;
	int                    limit = 0;

	softmc_top softmc_top_i (.*);

	softmc_checker checker_i (.*);

	initial begin
		forever #20 clk = ~clk;
	end

	// phy model: memory keyed by bank and column
	rdback_t mem [int];
	int      wr_keys [$];
	int      rd_keys [$];
	int      ret_due [$];
	rdback_t ret_data [$];
	int      mcycle = 0;

	always @(posedge clk) begin
		int key;
		mcycle++;
		if (!dfi_cs_n1 && dfi_ras_n1 && !dfi_cas_n1) begin
			key = {dfi_bank1, dfi_address1};
			if (!dfi_we_n1)
				wr_keys.push_back(key);
			else
				rd_keys.push_back(key);
		end
		if (dfi_wrdata_en && wr_keys.size() > 0)
			mem[wr_keys.pop_front()] = dfi_wrdata;
		if (dfi_rddata_en && rd_keys.size() > 0) begin
			key = rd_keys.pop_front();
			ret_due.push_back(mcycle + RET_DELAY);
			ret_data.push_back(mem.exists(key) ? mem[key] : '0);
		end
		#5;
		dfi_rddata_valid = 0;
		if (ret_due.size() > 0 && ret_due[0] == mcycle) begin
			dfi_rddata_valid = 1;
			dfi_rddata = ret_data.pop_front();
			void'(ret_due.pop_front());
		end
	end

	task automatic send_instr(instr_t w);
		bit got;
		@(posedge clk);
		#5;
		app_en = 1;
		app_instr = w;
		do begin
			@(negedge clk);
			got = app_ack;
			@(posedge clk);
		end while (!got);
		#5;
		app_en = 0;
	endtask

	task automatic queue_expected(logic [7:0] b);
		@(posedge clk);
		#5;
		expect_valid = 1;
		expect_byte = b;
		@(posedge clk);
		#5;
		expect_valid = 0;
	endtask

	task automatic drain_rdback(int n);
		while (!processing_iseq)
			@(negedge clk);
		while (processing_iseq)
			@(negedge clk);
		repeat (n) begin
			while (rdback_fifo_empty)
				@(negedge clk);
			@(posedge clk);
			#5;
			rdback_fifo_rden = 1;
			@(posedge clk);
			#5;
			rdback_fifo_rden = 0;
		end
	endtask

	initial begin
		int fd;
		int val;
		int n_instr;
		int pending;
		string line;
		string lines [$];
		n_instr = 0;
		pending = 0;
		fd = $fopen("bench/softmc_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/softmc_stimulus.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			while ($fgets(line, fd) > 0) begin
				lines.push_back(line);
				if (line[0] == "I")
					n_instr++;
			end
			$fclose(fd);
			limit = n_instr * 64 + 2000;

			repeat (8) @(posedge clk);
			#5;
			rst = 0;

			foreach (lines[i]) begin
				line = lines[i];
				if (line[0] == "I") begin
					void'($sscanf(line.substr(2, line.len() - 1), "%h", val));
					send_instr(val);
					repeat ($unsigned($random(seed)) % 3) @(posedge clk); // idle gap
				end else if (line[0] == "X") begin
					void'($sscanf(line.substr(2, line.len() - 1), "%h", val));
					queue_expected(val[7:0]);
					pending++;
				end else if (line[0] == "R") begin
					drain_rdback(pending);
					pending = 0;
				end
			end

			repeat (RD_LAT + RET_DELAY + 4) @(posedge clk);
			#5;
			end_check = 1;
			@(posedge clk);
			#5;
			end_check = 0;
			@(posedge clk);
			$display("checks: %0d errors: %0d", checks, errors);
			if (errors == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

	// watchdog
	initial begin
		wait (limit != 0);
		repeat (limit) @(posedge clk);
		$display("timeout: stimulus did not finish within %0d cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: compile.f
design/softmc_pkg.sv
design/sync_fifo.sv
design/iseq_exec.sv
design/dfi_data_path.sv
design/softmc_top.sv
bench/softmc_checker.sv
bench/softmc_tb.sv

// File: design/dfi_data_path.sv
module dfi_data_path import softmc_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_issue,   // write command on the dfi this cycle
	input  logic       rd_issue,   // read command on the dfi this cycle
	input  logic       wdata_load,
	input  logic [7:0] wdata_byte,
	output logic       dfi_wrdata_en,
	output rdback_t    dfi_wrdata,
	output logic       dfi_rddata_en
);

	localparam int REPEAT = RDBACK_WIDTH / 8;

	logic [7:0]        pattern;
	logic [WR_LAT-1:0] wr_pipe;
	logic [RD_LAT-1:0] rd_pipe;
	logic [7:0]        wr_byte [WR_LAT]; // pattern of the write in each stage

	// write pattern, zero out of reset
	always_ff @(posedge clk) begin
		if (rst)
			pattern <= '0;
		else if (wdata_load)
			pattern <= wdata_byte;
	end

	// one stage per cycle of write latency
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_pipe <= '0;
			for (int i = 0; i < WR_LAT; i++)
				wr_byte[i] <= '0;
		end else begin
			wr_pipe    <= (wr_pipe << 1) | WR_LAT'(wr_issue);
			wr_byte[0] <= pattern; // pattern as of the command cycle
			for (int i = 1; i < WR_LAT; i++)
				wr_byte[i] <= wr_byte[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rd_pipe <= '0;
		else
			rd_pipe <= (rd_pipe << 1) | RD_LAT'(rd_issue);
	end

	assign dfi_wrdata_en = wr_pipe[WR_LAT-1];
	assign dfi_rddata_en = rd_pipe[RD_LAT-1];

	// byte repeated across every dq beat
	assign dfi_wrdata = {REPEAT{wr_byte[WR_LAT-1]}};

endmodule

// File: design/iseq_exec.sv
module iseq_exec import softmc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  end_accepted, // an END went into the queue
	input  logic                  instr_valid,
	input  instr_t                instr,
	output logic                  instr_pop,
	output logic                  processing_iseq,
	output logic [ROW_WIDTH-1:0]  dfi_address0,
	output logic [ROW_WIDTH-1:0]  dfi_address1,
	output logic [BANK_WIDTH-1:0] dfi_bank0,
	output logic [BANK_WIDTH-1:0] dfi_bank1,
	output logic [CKE_WIDTH-1:0]  dfi_cke0,
	output logic [CKE_WIDTH-1:0]  dfi_cke1,
	output logic [CS_WIDTH-1:0]   dfi_cs_n0,
	output logic [CS_WIDTH-1:0]   dfi_cs_n1,
	output logic                  dfi_ras_n0,
	output logic                  dfi_ras_n1,
	output logic                  dfi_cas_n0,
	output logic                  dfi_cas_n1,
	output logic                  dfi_we_n0,
	output logic                  dfi_we_n1,
	output logic                  wr_issue,
	output logic                  rd_issue,
	output logic                  wdata_load,
	output logic [7:0]            wdata_byte
);

	localparam int PEND_W = $clog2(IQ_DEPTH + 1);

	logic [PEND_W-1:0]    pend_cnt; // sequences queued but not yet run
	logic [ROW_WIDTH-1:0] wait_cnt;
	logic [ROW_WIDTH-1:0] wait_len;
	logic [3:0]           op;
	logic                 do_ddr;
	logic                 do_wait;
	logic                 do_set;
	logic                 do_end;
	logic                 row_cmd;
	logic                 col_access;
	logic [CKE_WIDTH-1:0] cke_q;

	assign op      = instr[OP_HI:OP_LO];
	assign row_cmd = instr[CAS_N_BIT]; // cas_n high selects slot 0

	// one pop per cycle while a full sequence is queued and no WAIT runs
	assign instr_pop = (pend_cnt != '0) && (wait_cnt == '0);

	assign do_ddr  = instr_pop && (op == OP_DDR);
	assign do_wait = instr_pop && (op == OP_WAIT);
	assign do_set  = instr_pop && (op == OP_SET_WDATA);
	assign do_end  = instr_pop && (op == OP_END);

	// read or write: selected, ras_n high, cas_n low
	assign col_access = do_ddr && !row_cmd && !instr[CS_N_BIT] && instr[RAS_N_BIT];

	// the WAIT's own NOP cycle counts as the first one
	assign wait_len = (instr[ADDR_HI:ADDR_LO] == '0) ? '0 : instr[ADDR_HI:ADDR_LO] - 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_cnt <= '0;
		end else if (end_accepted && !do_end) begin
			pend_cnt <= pend_cnt + 1'b1;
		end else if (do_end && !end_accepted) begin
			pend_cnt <= pend_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			wait_cnt <= '0;
		else if (do_wait)
			wait_cnt <= wait_len;
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			processing_iseq <= 1'b0;
		else if (do_end)
			processing_iseq <= 1'b0;
		else if (instr_pop)
			processing_iseq <= 1'b1;
	end

	// nop on both slots unless a ddr command goes out
	always_ff @(posedge clk) begin
		dfi_address0 <= '0;
		dfi_bank0    <= '0;
		dfi_cs_n0    <= '1;
		dfi_ras_n0   <= 1'b1;
		dfi_cas_n0   <= 1'b1;
		dfi_we_n0    <= 1'b1;
		dfi_address1 <= '0;
		dfi_bank1    <= '0;
		dfi_cs_n1    <= '1;
		dfi_ras_n1   <= 1'b1;
		dfi_cas_n1   <= 1'b1;
		dfi_we_n1    <= 1'b1;
		if (!rst && do_ddr && row_cmd) begin
			dfi_address0 <= instr[ADDR_HI:ADDR_LO];
			dfi_bank0    <= instr[BANK_HI:BANK_LO];
			dfi_cs_n0    <= {CS_WIDTH{instr[CS_N_BIT]}};
			dfi_ras_n0   <= instr[RAS_N_BIT];
			dfi_cas_n0   <= instr[CAS_N_BIT];
			dfi_we_n0    <= instr[WE_N_BIT];
		end
		if (!rst && do_ddr && !row_cmd) begin
			dfi_address1 <= instr[ADDR_HI:ADDR_LO];
			dfi_bank1    <= instr[BANK_HI:BANK_LO];
			dfi_cs_n1    <= {CS_WIDTH{instr[CS_N_BIT]}};
			dfi_ras_n1   <= instr[RAS_N_BIT];
			dfi_cas_n1   <= instr[CAS_N_BIT];
			dfi_we_n1    <= instr[WE_N_BIT];
		end
	end

	// cke is level, kept from the last ddr command
	always_ff @(posedge clk) begin
		if (rst)
			cke_q <= '0;
		else if (do_ddr)
			cke_q <= {CKE_WIDTH{instr[CKE_BIT]}};
	end

	assign dfi_cke0 = cke_q;
	assign dfi_cke1 = cke_q;

	// strobes line up with the command cycle on the dfi
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_issue   <= 1'b0;
			rd_issue   <= 1'b0;
			wdata_load <= 1'b0;
		end else begin
			wr_issue   <= col_access && !instr[WE_N_BIT];
			rd_issue   <= col_access && instr[WE_N_BIT];
			wdata_load <= do_set;
		end
	end

	always_ff @(posedge clk) begin
		if (do_set)
			wdata_byte <= instr[WDATA_HI:WDATA_LO];
	end

	// a counted END means its whole sequence already sits in the queue
	a_pop_valid: assert property (
		@(posedge clk) disable iff (rst) instr_pop |-> instr_valid
	) else $error("iseq_exec: pop from empty instruction queue");

endmodule

// File: design/softmc_pkg.sv
package softmc_pkg;

	// instruction word from the host
	localparam int INSTR_WIDTH = 32;
	typedef logic [INSTR_WIDTH-1:0] instr_t;

	// dfi address and control widths
	localparam int ROW_WIDTH  = 16;
	localparam int BANK_WIDTH = 3;
	localparam int CKE_WIDTH  = 1;
	localparam int CS_WIDTH   = 1;

	localparam int DQ_WIDTH     = 64;
	localparam int RDBACK_WIDTH = 4 * DQ_WIDTH; // four dq beats per clk
	typedef logic [RDBACK_WIDTH-1:0] rdback_t;

	// instruction fields
	localparam int OP_HI     = 31;
	localparam int OP_LO     = 28;
	localparam int CKE_BIT   = 23;
	localparam int CS_N_BIT  = 22;
	localparam int RAS_N_BIT = 21;
	localparam int CAS_N_BIT = 20;
	localparam int WE_N_BIT  = 19;
	localparam int BANK_HI   = 18;
	localparam int BANK_LO   = 16;
	localparam int ADDR_HI   = 15; // address, or the count of a WAIT
	localparam int ADDR_LO   = 0;
	localparam int WDATA_HI  = 7;  // pattern byte of SET_WDATA
	localparam int WDATA_LO  = 0;

	// opcodes
	localparam logic [3:0] OP_DDR       = 4'b0100;
	localparam logic [3:0] OP_WAIT      = 4'b0001;
	localparam logic [3:0] OP_SET_WDATA = 4'b1000;
	localparam logic [3:0] OP_END       = 4'b1110;

	// queue depths
	localparam int IQ_DEPTH     = 16;
	localparam int RDBACK_DEPTH = 16;

	// command to data enable, in clk cycles
	localparam int WR_LAT = 4;
	localparam int RD_LAT = 4;

endpackage

// File: design/softmc_top.sv
module softmc_top import softmc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  app_en,
	input  instr_t                app_instr,
	output logic                  app_ack,
	output logic                  iq_full,
	output logic                  processing_iseq,
	input  logic                  rdback_fifo_rden,
	output logic                  rdback_fifo_empty,
	output rdback_t               rdback_data,
	output logic [ROW_WIDTH-1:0]  dfi_address0,
	output logic [ROW_WIDTH-1:0]  dfi_address1,
	output logic [BANK_WIDTH-1:0] dfi_bank0,
	output logic [BANK_WIDTH-1:0] dfi_bank1,
	output logic [CKE_WIDTH-1:0]  dfi_cke0,
	output logic [CKE_WIDTH-1:0]  dfi_cke1,
	output logic [CS_WIDTH-1:0]   dfi_cs_n0,
	output logic [CS_WIDTH-1:0]   dfi_cs_n1,
	output logic                  dfi_ras_n0,
	output logic                  dfi_ras_n1,
	output logic                  dfi_cas_n0,
	output logic                  dfi_cas_n1,
	output logic                  dfi_we_n0,
	output logic                  dfi_we_n1,
	output logic                  dfi_wrdata_en,
	output rdback_t               dfi_wrdata,
	output logic                  dfi_rddata_en,
	input  rdback_t               dfi_rddata,
	input  logic                  dfi_rddata_valid
);

	logic       iq_push;
	logic       iq_push_ready;
	logic       instr_valid;
	instr_t     instr;
	logic       instr_pop;
	logic       end_accepted;
	logic       wr_issue;
	logic       rd_issue;
	logic       wdata_load;
	logic [7:0] wdata_byte;
	logic       rdback_valid;
	logic       rdback_pop;

	assign iq_full      = !iq_push_ready;
	assign iq_push      = app_en && iq_push_ready; // instruction taken
	assign app_ack      = iq_push;
	assign end_accepted = iq_push && (app_instr[OP_HI:OP_LO] == OP_END);

	assign rdback_fifo_empty = !rdback_valid;
	assign rdback_pop        = rdback_fifo_rden && rdback_valid;

	sync_fifo #(.item_t(instr_t), .DEPTH(IQ_DEPTH)) iq_fifo (
		.clk(clk), .rst(rst),
		.push_valid(iq_push), .push_data(app_instr), .push_ready(iq_push_ready),
		.pop_valid(instr_valid), .pop_data(instr), .pop_ready(instr_pop)
	);

	iseq_exec u_exec (
		.clk(clk), .rst(rst),
		.end_accepted(end_accepted), .instr_valid(instr_valid), .instr(instr),
		.instr_pop(instr_pop), .processing_iseq(processing_iseq),
		.dfi_address0(dfi_address0), .dfi_address1(dfi_address1),
		.dfi_bank0(dfi_bank0), .dfi_bank1(dfi_bank1),
		.dfi_cke0(dfi_cke0), .dfi_cke1(dfi_cke1),
		.dfi_cs_n0(dfi_cs_n0), .dfi_cs_n1(dfi_cs_n1),
		.dfi_ras_n0(dfi_ras_n0), .dfi_ras_n1(dfi_ras_n1),
		.dfi_cas_n0(dfi_cas_n0), .dfi_cas_n1(dfi_cas_n1),
		.dfi_we_n0(dfi_we_n0), .dfi_we_n1(dfi_we_n1),
		.wr_issue(wr_issue), .rd_issue(rd_issue),
		.wdata_load(wdata_load), .wdata_byte(wdata_byte)
	);

	dfi_data_path u_data (
		.clk(clk), .rst(rst),
		.wr_issue(wr_issue), .rd_issue(rd_issue),
		.wdata_load(wdata_load), .wdata_byte(wdata_byte),
		.dfi_wrdata_en(dfi_wrdata_en), .dfi_wrdata(dfi_wrdata),
		.dfi_rddata_en(dfi_rddata_en)
	);

	// every valid word from the phy is queued for the host
	sync_fifo #(.item_t(rdback_t), .DEPTH(RDBACK_DEPTH)) rdback_fifo (
		.clk(clk), .rst(rst),
		.push_valid(dfi_rddata_valid), .push_data(dfi_rddata), .push_ready(),
		.pop_valid(rdback_valid), .pop_data(rdback_data), .pop_ready(rdback_pop)
	);

endmodule

// File: design/sync_fifo.sv
module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = 16
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  push_valid,
	input  item_t push_data,
	output logic  push_ready,
	output logic  pop_valid,
	output item_t pop_data,
	input  logic  pop_ready
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t             mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count; // occupied entries
	logic              do_push;
	logic              do_pop;

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid  = (count != '0);
	assign pop_data   = mem[rd_ptr]; // oldest entry

	assign do_push = push_valid && push_ready;
	assign do_pop  = pop_ready && pop_valid;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// the producer has to respect back-pressure
	a_no_push_full: assert property (
		@(posedge clk) disable iff (rst) push_valid |-> push_ready
	) else $error("sync_fifo: push while full");

	// consumer only pops what is there
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (rst) pop_ready |-> pop_valid
	) else $error("sync_fifo: pop while empty");

endmodule

// File: run.sh
#!/bin/sh
# build and run the softmc testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module softmc_tb -o softmc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/softmc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "$out" | grep -qx "TEST PASS" || exit 1
exit 0
